// File: Makefile
TOP = tb_rv_pipeline_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

// File: flist.f
hdl/rv_isa_pkg.sv
hdl/core_types_pkg.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/rv_pipeline_core.sv
testbench/tb_rv_pipeline_core.sv

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu import core_types_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    // only the low five bits of b shift
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   result = {31'b0, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // branch compare runs as sub and tests this
    assign zero = (result == '0);

    // arithmetic shift must replicate the sign of a
    always_comb begin
        if (op == alu_sra) begin
            assert (result[31] == a[31])
                else $error("sra lost the sign bit of a");
        end
    end

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit import rv_isa_pkg::*, core_types_pkg::*; (
    input  insn_t   insn,
    output logic    reg_write,
    output logic    mem_read,
    output logic    mem_write,
    output logic    branch,
    output logic    b_is_imm,
    output a_src_t  a_src,
    output wb_src_t wb_src,
    output alu_op_t alu_op
);

    // funct7 only matters for register forms, except srai
    function automatic alu_op_t decode_alu(logic [2:0] funct3, logic alt, logic is_r);
        case (funct3)
            f3_add:  return (is_r && alt) ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    logic alt;

    assign alt = (insn[31:25] == f7_alt);

    always_comb begin
        // bubble unless the opcode is known
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        b_is_imm  = 1'b0;
        a_src     = a_reg;
        wb_src    = wb_alu;
        alu_op    = alu_add;
        case (insn[6:0])
            op_r: begin
                reg_write = 1'b1;
                alu_op    = decode_alu(insn[14:12], alt, 1'b1);
            end
            op_imm: begin
                reg_write = 1'b1;
                b_is_imm  = 1'b1;
                alu_op    = decode_alu(insn[14:12], alt, 1'b0);
            end
            op_load: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                b_is_imm  = 1'b1;
                wb_src    = wb_mem;
            end
            op_store: begin
                mem_write = 1'b1;
                b_is_imm  = 1'b1;
            end
            // compare rs1 and rs2 by subtraction
            op_branch: begin
                branch = 1'b1;
                alu_op = alu_sub;
            end
            op_lui: begin
                reg_write = 1'b1;
                b_is_imm  = 1'b1;
                a_src     = a_zero;
                alu_op    = alu_pass_b;
            end
            op_auipc: begin
                reg_write = 1'b1;
                b_is_imm  = 1'b1;
                a_src     = a_pc;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("load and store decoded together");
    end

endmodule

// File: hdl/core_types_pkg.sv
package core_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // execute unit operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    // value written back to rd
    typedef enum logic {
        wb_alu,
        wb_mem
    } wb_src_t;

    // first alu operand
    typedef enum logic [1:0] {
        a_reg,
        a_pc,
        a_zero
    } a_src_t;

endpackage

// File: hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen import rv_isa_pkg::*, core_types_pkg::*; (
    input  insn_t insn,
    output word_t imm
);

    // format follows the opcode, bit 31 is always the sign
    always_comb begin
        case (insn[6:0])
            // I type, arithmetic immediates and loads
            op_imm, op_load: begin
                imm = {{20{insn[31]}}, insn[31:20]};
            end
            op_store: begin
                imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
            end
            // branch offsets are in half words
            op_branch: begin
                imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            op_lui, op_auipc: begin
                imm = {insn[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file import core_types_pkg::*; (
    input  logic     CLK,
    input  logic     RESET_N,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    input  logic     we,
    output word_t    rdata1,
    output word_t    rdata2
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // same cycle write is visible to the reader
    function automatic word_t read_reg(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (we && rd == idx) begin
            return wdata;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rdata1 = read_reg(rs1);
        rdata2 = read_reg(rs2);
    end

    // a stored value comes back from the array one cycle later
    write_read_back: assert property (@(posedge CLK) disable iff (!RESET_N)
        (we && rd != '0) |=>
            (rs1 != $past(rd) || (we && rd == rs1) || rdata1 == $past(wdata)))
        else $error("register read did not return the value last written to it");

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // raw instruction word
    typedef logic [31:0] insn_t;

    // major opcodes, bits 6:0
    localparam logic [6:0] op_r      = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // funct3 for register and immediate arithmetic
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // funct7 selecting sub and the arithmetic shift
    localparam logic [6:0] f7_alt  = 7'b0100000;

endpackage

// File: hdl/rv_pipeline_core.sv
`timescale 1ns/1ps

module rv_pipeline_core import rv_isa_pkg::*, core_types_pkg::*; #(
    parameter int addr_width = 10
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    output logic [addr_width-1:0] iaddr,
    input  insn_t                 idata,
    output logic [addr_width-1:0] daddr,
    input  word_t                 ddata_r,
    output word_t                 ddata_w,
    output logic                  mem_write,
    output logic                  mem_read
);

    // byte address width of the pc
    localparam int pc_width = addr_width + 2;

    logic [pc_width-1:0] pc, pc_next;

    // decode stage
    logic    dec_reg_write, dec_mem_read, dec_mem_write, dec_branch, dec_b_is_imm;
    a_src_t  dec_a_src;
    wb_src_t dec_wb_src;
    alu_op_t dec_alu_op;
    word_t   dec_imm, rf_rdata1, rf_rdata2;

    // id/ex register
    logic                id_ex_reg_write, id_ex_mem_read, id_ex_mem_write;
    logic                id_ex_branch, id_ex_b_is_imm;
    a_src_t              id_ex_a_src;
    wb_src_t             id_ex_wb_src;
    alu_op_t             id_ex_alu_op;
    logic [pc_width-1:0] id_ex_pc;
    word_t               id_ex_rs1_data, id_ex_rs2_data, id_ex_imm;
    reg_idx_t            id_ex_rd;
    logic [2:0]          id_ex_funct3;

    // execute stage
    word_t alu_a, alu_b, alu_result, br_target;
    logic  alu_zero;

    // ex/mem register
    logic       ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write, ex_mem_branch;
    wb_src_t    ex_mem_wb_src;
    word_t      ex_mem_result, ex_mem_target, ex_mem_rs2_data;
    logic       ex_mem_zero;
    reg_idx_t   ex_mem_rd;
    logic [2:0] ex_mem_funct3;

    // memory stage and mem/wb register
    logic     branch_taken;
    word_t    wb_value, mem_wb_data;
    logic     mem_wb_reg_write;
    reg_idx_t mem_wb_rd;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign iaddr = pc[pc_width-1:2];

    control_unit u_control (
        .insn      (idata),
        .reg_write (dec_reg_write),
        .mem_read  (dec_mem_read),
        .mem_write (dec_mem_write),
        .branch    (dec_branch),
        .b_is_imm  (dec_b_is_imm),
        .a_src     (dec_a_src),
        .wb_src    (dec_wb_src),
        .alu_op    (dec_alu_op)
    );

    imm_gen u_imm_gen (
        .insn (idata),
        .imm  (dec_imm)
    );

    register_file u_regs (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (idata[19:15]),
        .rs2     (idata[24:20]),
        .rd      (mem_wb_rd),
        .wdata   (mem_wb_data),
        .we      (mem_wb_reg_write),
        .rdata1  (rf_rdata1),
        .rdata2  (rf_rdata2)
    );

    // pipeline control, cleared so reset leaves only bubbles
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex_reg_write  <= 1'b0;
            id_ex_mem_read   <= 1'b0;
            id_ex_mem_write  <= 1'b0;
            id_ex_branch     <= 1'b0;
            id_ex_b_is_imm   <= 1'b0;
            id_ex_a_src      <= a_reg;
            id_ex_wb_src     <= wb_alu;
            id_ex_alu_op     <= alu_add;
            ex_mem_reg_write <= 1'b0;
            ex_mem_mem_read  <= 1'b0;
            ex_mem_mem_write <= 1'b0;
            ex_mem_branch    <= 1'b0;
            ex_mem_wb_src    <= wb_alu;
            mem_wb_reg_write <= 1'b0;
        end else begin
            id_ex_reg_write  <= dec_reg_write;
            id_ex_mem_read   <= dec_mem_read;
            id_ex_mem_write  <= dec_mem_write;
            id_ex_branch     <= dec_branch;
            id_ex_b_is_imm   <= dec_b_is_imm;
            id_ex_a_src      <= dec_a_src;
            id_ex_wb_src     <= dec_wb_src;
            id_ex_alu_op     <= dec_alu_op;
            ex_mem_reg_write <= id_ex_reg_write;
            ex_mem_mem_read  <= id_ex_mem_read;
            ex_mem_mem_write <= id_ex_mem_write;
            ex_mem_branch    <= id_ex_branch;
            ex_mem_wb_src    <= id_ex_wb_src;
            mem_wb_reg_write <= ex_mem_reg_write;
        end
    end

    // pipeline payload
    always_ff @(posedge CLK) begin
        id_ex_pc        <= pc;
        id_ex_rs1_data  <= rf_rdata1;
        id_ex_rs2_data  <= rf_rdata2;
        id_ex_imm       <= dec_imm;
        id_ex_rd        <= idata[11:7];
        id_ex_funct3    <= idata[14:12];
        ex_mem_result   <= alu_result;
        ex_mem_zero     <= alu_zero;
        ex_mem_target   <= br_target;
        ex_mem_rs2_data <= id_ex_rs2_data;
        ex_mem_rd       <= id_ex_rd;
        ex_mem_funct3   <= id_ex_funct3;
        mem_wb_data     <= wb_value;
        mem_wb_rd       <= ex_mem_rd;
    end

    always_comb begin
        case (id_ex_a_src)
            a_pc:    alu_a = word_t'(id_ex_pc);
            a_zero:  alu_a = '0;
            default: alu_a = id_ex_rs1_data;
        endcase
    end

    assign alu_b = id_ex_b_is_imm ? id_ex_imm : id_ex_rs2_data;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (id_ex_alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // branch target from the pc of the branch itself
    alu u_target_adder (
        .a      (word_t'(id_ex_pc)),
        .b      (id_ex_imm),
        .op     (alu_add),
        .result (br_target),
        .zero   ()
    );

    assign daddr     = ex_mem_result[pc_width-1:2];
    assign ddata_w   = ex_mem_rs2_data;
    assign mem_write = ex_mem_mem_write;
    assign mem_read  = ex_mem_mem_read;

    // resolved two instructions late, both delay slots run
    assign branch_taken = ex_mem_branch &&
                          ((ex_mem_funct3 == f3_beq && ex_mem_zero) ||
                           (ex_mem_funct3 == f3_bne && !ex_mem_zero));

    assign pc_next  = branch_taken ? ex_mem_target[pc_width-1:0] : pc + pc_width'(4);
    assign wb_value = (ex_mem_wb_src == wb_mem) ? ddata_r : ex_mem_result;

    // a taken branch must land inside instruction memory on a word boundary
    target_in_range: assert property (@(posedge CLK) disable iff (!RESET_N)
        branch_taken |-> (ex_mem_target[31:pc_width] == '0 && ex_mem_target[1:0] == 2'b00))
        else $error("branch target 0x%08h outside instruction memory", ex_mem_target);

endmodule

// File: testbench/tb_rv_pipeline_core.sv
`timescale 1ns/1ps

module tb_rv_pipeline_core
    import rv_isa_pkg::*, core_types_pkg::*;
();

    localparam int          addr_width   = 10;
    localparam int          depth        = 1 << addr_width;
    localparam int          reset_cycles = 5;
    localparam insn_t       nop          = 32'h0000_0013;
    // final store of the program lands here, byte offset 2044
    localparam logic [9:0]  marker_waddr = 10'd511;

    logic                  CLK;
    logic                  RESET_N;
    logic [addr_width-1:0] iaddr;
    logic [addr_width-1:0] daddr;
    insn_t                 idata;
    word_t                 ddata_r;
    word_t                 ddata_w;
    logic                  mem_write;
    logic                  mem_read;

    insn_t imem [0:depth-1];
    word_t dmem [0:depth-1];
    word_t ref_dmem [0:depth-1];

    int         prog_len;
    int         st_ptr;
    logic       prog_ready;
    logic [15:0] lfsr_state;

    logic [addr_width-1:0] exp_st_addr [$];
    word_t                 exp_st_data [$];
    logic [addr_width-1:0] exp_ld_addr [$];
    logic [addr_width-1:0] exp_a;
    word_t                 exp_d;

    int   errors;
    int   stores_seen;
    int   loads_seen;
    logic done;

    rv_pipeline_core #(
        .addr_width (addr_width)
    ) DUT (
        .CLK       (CLK),
        .RESET_N   (RESET_N),
        .iaddr     (iaddr),
        .idata     (idata),
        .daddr     (daddr),
        .ddata_r   (ddata_r),
        .ddata_w   (ddata_w),
        .mem_write (mem_write),
        .mem_read  (mem_read)
    );

    always #4 CLK = ~CLK;

    // both memories answer in the same cycle
    assign idata   = imem[iaddr];
    assign ddata_r = dmem[daddr];

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    function automatic word_t fill_word(int a);
        return 32'h5ee0_0000 ^ (word_t'(a) * 32'h0001_0001);
    endfunction

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic insn_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_r};
    endfunction

    function automatic insn_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic insn_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic insn_t enc_b(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic insn_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    task automatic put(insn_t insn);
        imem[prog_len] = insn;
        prog_len++;
    endtask

    // two nops keep producers clear of their consumers
    task automatic put_spaced(insn_t insn);
        put(insn);
        put(nop);
        put(nop);
    endtask

    task automatic store_result(reg_idx_t rs);
        put_spaced(enc_s(12'(st_ptr * 4), rs, 5'd0));
        st_ptr++;
    endtask

    task automatic build_program();
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [11:0] imm;
        // random operands in x1 to x8
        for (int r = 1; r <= 8; r++) begin
            put_spaced(enc_u(20'(rand_bits(20)), reg_idx_t'(r), op_lui));
            put_spaced(enc_i(12'(rand_bits(12)), reg_idx_t'(r), f3_add, reg_idx_t'(r), op_imm));
        end
        // register forms, v selects sub and sra
        for (int round = 0; round < 2; round++) begin
            for (int f = 0; f < 8; f++) begin
                for (int v = 0; v < 2; v++) begin
                    if (v == 0 || f == 0 || f == 5) begin
                        rs1 = reg_idx_t'(1 + rand_bits(3));
                        rs2 = reg_idx_t'(1 + rand_bits(3));
                        put_spaced(enc_r(v != 0 ? f7_alt : 7'd0, rs2, rs1, 3'(f), 5'd20));
                        store_result(5'd20);
                    end
                end
            end
        end
        // immediate forms, first round of slti and sltiu is negative
        for (int round = 0; round < 2; round++) begin
            for (int f = 0; f < 8; f++) begin
                for (int v = 0; v < 2; v++) begin
                    if (v == 0 || f == 5) begin
                        rs1 = reg_idx_t'(1 + rand_bits(3));
                        imm = 12'(rand_bits(12));
                        if (f == 1 || f == 5) begin
                            imm = {v != 0 ? f7_alt : 7'd0, imm[4:0]};
                        end else if ((f == 2 || f == 3) && round == 0) begin
                            imm[11] = 1'b1;
                        end
                        put_spaced(enc_i(imm, rs1, 3'(f), 5'd21, op_imm));
                        store_result(5'd21);
                    end
                end
            end
        end
        put_spaced(enc_u(20'(rand_bits(20)), 5'd22, op_lui));
        store_result(5'd22);
        put_spaced(enc_u(20'(rand_bits(20)), 5'd23, op_auipc));
        store_result(5'd23);
        // beq taken, beq not taken, bne not taken, bne taken
        for (int c = 0; c < 4; c++) begin
            rs2 = (c % 2 == 0) ? 5'd1 : 5'd2;
            put(enc_b(13'd24, rs2, 5'd1, (c < 2) ? f3_beq : f3_bne));
            for (int s = 0; s < 3; s++) begin
                put(enc_s(12'((st_ptr + s) * 4), reg_idx_t'(3 + s), 5'd0));
            end
            put(nop);
            put(nop);
            put_spaced(enc_s(12'((st_ptr + 3) * 4), 5'd6, 5'd0));
            st_ptr += 4;
        end
        // store then load back, plus a load of untouched memory
        put_spaced(enc_s(12'(st_ptr * 4), 5'd7, 5'd0));
        put_spaced(enc_i(12'(st_ptr * 4), 5'd0, 3'b010, 5'd24, op_load));
        st_ptr++;
        store_result(5'd24);
        put_spaced(enc_i(12'd1200, 5'd0, 3'b010, 5'd25, op_load));
        store_result(5'd25);
        put_spaced(enc_s(12'd2044, 5'd1, 5'd0));
    endtask

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            3'd3: r = word_t'(a < b);
            3'd4: r = a ^ b;
            3'd5: begin
                r = a >> b[4:0];
                if (alt && a[31]) begin
                    r = r | ~(32'hffff_ffff >> b[4:0]);
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // sequential ISA model, a taken branch redirects after two more instructions
    function automatic void run_model();
        word_t    regs [32];
        word_t    pc, next_pc, target, a, b, result, addr;
        insn_t    insn;
        int       pending;
        logic     taken, wr;
        regs = '{default: '0};
        pc = '0;
        target = '0;
        pending = 0;
        for (int step = 0; step < 4 * depth; step++) begin
            insn = imem[pc[addr_width+1:2]];
            a = regs[insn[19:15]];
            b = regs[insn[24:20]];
            result = '0;
            taken = 1'b0;
            wr = 1'b1;
            case (insn[6:0])
                op_r:     result = alu_ref(insn[14:12], insn[30], a, b);
                op_imm:   result = alu_ref(insn[14:12], insn[30] && insn[14:12] == f3_sr, a,
                                           {{20{insn[31]}}, insn[31:20]});
                op_lui:   result = {insn[31:12], 12'b0};
                op_auipc: result = pc + {insn[31:12], 12'b0};
                op_load: begin
                    addr = a + {{20{insn[31]}}, insn[31:20]};
                    exp_ld_addr.push_back(addr[addr_width+1:2]);
                    result = ref_dmem[addr[addr_width+1:2]];
                end
                op_store: begin
                    wr = 1'b0;
                    addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                    exp_st_addr.push_back(addr[addr_width+1:2]);
                    exp_st_data.push_back(b);
                    ref_dmem[addr[addr_width+1:2]] = b;
                    if (addr[addr_width+1:2] == marker_waddr) begin
                        return;
                    end
                end
                op_branch: begin
                    wr = 1'b0;
                    taken = (insn[14:12] == f3_beq) ? (a == b) : (a != b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && insn[11:7] != 5'd0) begin
                regs[insn[11:7]] = result;
            end
            next_pc = pc + 32'd4;
            if (pending > 0) begin
                pending--;
                if (pending == 0) begin
                    next_pc = target;
                end
            end
            if (taken) begin
                pending = 2;
                target = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
            end
            pc = next_pc;
        end
    endfunction

    // bus values are stable mid cycle
    always @(negedge CLK) begin
        if (mem_write) begin
            assert (exp_st_addr.size() > 0)
                else begin
                    errors++;
                    $display("store to word 0x%0h at %0t after the last program store", daddr,
                             $time);
                end
            if (exp_st_addr.size() > 0) begin
                exp_a = exp_st_addr.pop_front();
                exp_d = exp_st_data.pop_front();
                stores_seen++;
                assert (daddr == exp_a)
                    else begin
                        errors++;
                        $display("Error at %0t: daddr = 0x%0h, expected 0x%0h", $time, daddr,
                                 exp_a);
                    end
                assert (ddata_w == exp_d)
                    else begin
                        errors++;
                        $display("Error at %0t: ddata_w = 0x%08h, expected 0x%08h", $time,
                                 ddata_w, exp_d);
                    end
                if (exp_a == marker_waddr) begin
                    done = 1'b1;
                end
            end
        end
        if (mem_read) begin
            assert (exp_ld_addr.size() > 0)
                else begin
                    errors++;
                    $display("mem_read high at %0t with no load left in the program", $time);
                end
            if (exp_ld_addr.size() > 0) begin
                exp_a = exp_ld_addr.pop_front();
                loads_seen++;
                assert (daddr == exp_a)
                    else begin
                        errors++;
                        $display("Error at %0t: daddr = 0x%0h, expected 0x%0h on load", $time,
                                 daddr, exp_a);
                    end
            end
        end
    end

    initial begin
        CLK = 1'b0;
        RESET_N = 1'b0;
        done = 1'b0;
        prog_ready = 1'b0;
        errors = 0;
        stores_seen = 0;
        loads_seen = 0;
        prog_len = 0;
        st_ptr = 0;
        lfsr_state = 16'd13858;
        for (int i = 0; i < depth; i++) begin
            imem[i] = nop;
            dmem[i] <= fill_word(i);
            ref_dmem[i] = fill_word(i);
        end
        build_program();
        run_model();
        prog_ready = 1'b1;
        repeat (reset_cycles) @(posedge CLK);
        #1;
        RESET_N = 1'b1;
        wait (done);
        repeat (4) @(posedge CLK);
        assert (exp_st_addr.size() == 0 && exp_ld_addr.size() == 0)
            else begin
                errors++;
                $display("%0d stores and %0d loads of the program never reached the bus",
                         exp_st_addr.size(), exp_ld_addr.size());
            end
        $display("errors: %0d, stores checked: %0d, loads checked: %0d", errors, stores_seen,
                 loads_seen);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // ten cycles per program instruction plus reset
    initial begin
        wait (prog_ready);
        repeat (prog_len * 10 + reset_cycles) @(posedge CLK);
        errors++;
        $display("timeout: the program did not reach its final store after %0d cycles",
                 prog_len * 10 + reset_cycles);
        $display("errors: %0d, stores checked: %0d, loads checked: %0d", errors, stores_seen,
                 loads_seen);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
